/* rtl/invsqrt_params.svh */
`ifndef INVSQRT_PARAMS_SVH
`define INVSQRT_PARAMS_SVH

// single-precision field widths
`define FP_EXP_W 8
`define FP_MAN_W 23

// guard bits kept at the three precision levels of the series
`define FP_RNE0_W 2
`define FP_RNE1_W 20
`define FP_RNE2_W 21

// returned for NaN, zero and negative operands
`define INVSQRT_QNAN 32'h7FC0_0000

// register stages from input port to output port
`define INVSQRT_LATENCY 6

`endif

/* rtl/invsqrt_pkg.sv */
`include "invsqrt_params.svh"

package invsqrt_pkg;

    //////////////////////////////////////////////////
    // fixed-point widths of the series terms
    // hidden bit included
    localparam int M1_W   = `FP_MAN_W + 1;
    localparam int A0_W   = M1_W + `FP_RNE0_W;
    localparam int A1_W   = (A0_W + `FP_RNE1_W) / 2;
    localparam int A3_W   = (A1_W + `FP_RNE2_W) / 2;
    localparam int A5_W   = A3_W / 2;
    // offset from the segment centre, top three zero bits dropped
    localparam int Y_W    = `FP_MAN_W - 3;
    // products before rounding
    localparam int Z2_W   = A1_W + `FP_RNE2_W - 7;
    localparam int A3Y2_W = A1_W + `FP_RNE2_W - 5;
    localparam int A1Y1_W = A0_W + `FP_RNE1_W - 5;
    localparam int A4Z2_W = A1_W + `FP_RNE2_W - 10;
    localparam int ZG1_W  = A0_W + `FP_RNE1_W - 9;
    localparam int A5Y_W  = A3_W - 6;
    localparam int A45_W  = A3_W - 2;
    localparam int ZT_W   = A3_W - 7;
    // terms after rounding
    localparam int Z_W    = A1_W - 7;
    localparam int A3Y_W  = A1_W - 5;
    localparam int A1Y_W  = A0_W - 5;
    localparam int A4Z_W  = A1_W - 10;
    localparam int GRP_W  = A1_W - 1;
    localparam int ZG_W   = A0_W - 9;
    localparam int SUM_W  = A0_W + 1;
    localparam int RES_W  = M1_W + 1;

    typedef struct packed {
        logic                 sign;
        logic [`FP_EXP_W-1:0] exp;
        logic [`FP_MAN_W-1:0] man;
    } fp32_t;

    typedef struct packed {
        logic neg;
        logic zero;
        logic nan_zero_neg;
        logic pos_inf;
    } case_flags_t;

    typedef struct packed {
        logic [A0_W-1:0] a0;
        logic [A1_W-1:0] a1;
        logic [A1_W-1:0] a2;
        logic [A3_W-1:0] a3;
        logic [A3_W-1:0] a4;
        logic [A5_W-1:0] a5;
    } coef_t;

    //////////////////////////////////////////////////
    // per-stage payloads
    typedef struct packed {
        case_flags_t          flags;
        // x at or above the segment centre
        logic                 above;
        logic [`FP_EXP_W-1:0] exp;
        coef_t                coef;
        logic [Y_W-1:0]       y;
    } unpack_t;

    typedef struct packed {
        case_flags_t          flags;
        logic                 above;
        logic [`FP_EXP_W-1:0] exp;
        logic [A0_W-1:0]      a0;
        logic [A1_W-1:0]      a2;
        logic [A3_W-1:0]      a4;
        logic [A5Y_W-1:0]     a5y;
        logic [A1Y1_W-1:0]    a1y_w;
        logic [Z2_W-1:0]      z_w;
        logic [A3Y2_W-1:0]    a3y_w;
    } prod_t;

    typedef struct packed {
        case_flags_t          flags;
        logic                 above;
        logic [`FP_EXP_W-1:0] exp;
        logic [A0_W-1:0]      a0;
        logic [A1_W-1:0]      a2;
        logic [A45_W-1:0]     a45;
        logic [A1Y_W-1:0]     a1y;
        logic [Z_W-1:0]       z;
        logic [ZT_W-1:0]      z_top;
        logic [A3Y_W-1:0]     a3y;
    } inner_t;

    typedef struct packed {
        case_flags_t          flags;
        logic                 above;
        logic [`FP_EXP_W-1:0] exp;
        logic [A0_W-1:0]      a0;
        logic [A1Y_W-1:0]     a1y;
        logic [Z_W-1:0]       z;
        logic [GRP_W-1:0]     grp;
    } group_t;

    typedef struct packed {
        case_flags_t          flags;
        logic                 above;
        logic [`FP_EXP_W-1:0] exp;
        logic [A0_W-1:0]      a0;
        logic [A1Y_W-1:0]     a1y;
        logic [ZG_W-1:0]      zg;
    } sum_in_t;

    typedef struct packed {
        fp32_t word;
        logic  invalid_op;
        logic  divide_by_zero;
    } result_t;

    // drop the low bits with round to nearest, ties to even
    function automatic logic [63:0] rne_round(input logic [63:0] val, input int unsigned drop);
        logic [63:0] kept;
        logic [63:0] rest_mask;
        logic        round_bit;
        logic        sticky;
        kept      = val >> drop;
        round_bit = val[drop-1];
        rest_mask = (64'd1 << (drop - 1)) - 64'd1;
        sticky    = |(val & rest_mask);
        return kept + {63'd0, round_bit & (sticky | kept[0])};
    endfunction

endpackage

/* rtl/invsqrt_coef_rom.sv */
`timescale 1ns/1ps

module invsqrt_coef_rom import invsqrt_pkg::*; (
    input  logic       i_odd_exp,
    input  logic [2:0] i_seg,
    output coef_t      o_coef
);

    // series of 1/sqrt(m) around the centre of each eighth of [1, 2)
    // the odd table folds the extra factor of two into m
    always_comb begin
        if (!i_odd_exp) begin
            case (i_seg)
                3'd0: o_coef = {26'h3e16d09, 23'h3a6fd3, 23'h293fe0, 22'h102d21, 22'h0d5257, 11'h169};
                3'd1: o_coef = {26'h3abafd5, 23'h31750b, 23'h1f3c73, 22'h0af5c5, 22'h081369, 11'h0c4};
                3'd2: o_coef = {26'h37dd20b, 23'h2a9019, 23'h185257, 22'h07b89e, 22'h0525bf, 11'h071};
                3'd3: o_coef = {26'h3561336, 23'h25223a, 23'h135fc5, 22'h059d9d, 22'h036b12, 11'h044};
                3'd4: o_coef = {26'h3333333, 23'h20c49c, 23'h0fba88, 22'h0431be, 22'h02594c, 11'h02b};
                3'd5: o_coef = {26'h314468c, 23'h1d3205, 23'h0cf9c9, 22'h033432, 22'h01a949, 11'h01c};
                3'd6: o_coef = {26'h2f89bad, 23'h1a3a55, 23'h0ada58, 22'h027eb3, 22'h013457, 11'h013};
                default: begin
                    o_coef = {26'h2dfa9cf, 23'h17bb28, 23'h092fac, 22'h01f9bc, 22'h00e466, 11'h00d};
                end
            endcase
        end else begin
            case (i_seg)
                3'd0: o_coef = {26'h2be754d, 23'h295232, 23'h1d2af6, 22'h0b7038, 22'h096b7a, 11'h0ff};
                3'd1: o_coef = {26'h298757d, 23'h22f8b6, 23'h161658, 22'h07bffb, 22'h05b5e1, 11'h08a};
                3'd2: o_coef = {26'h27806ca, 23'h1e18b4, 23'h1132b0, 22'h0575ae, 22'h03a3c9, 11'h050};
                3'd3: o_coef = {26'h25bec19, 23'h1a41eb, 23'h0db316, 22'h03f88c, 22'h026ac5, 11'h030};
                3'd4: o_coef = {26'h243430a, 23'h172ba4, 23'h0b1f30, 22'h02f740, 22'h01a92e, 11'h01f};
                3'd5: o_coef = {26'h22d651f, 23'h14a4ee, 23'h092cdc, 22'h0243f7, 22'h012cb9, 11'h014};
                3'd6: o_coef = {26'h219d4c6, 23'h128bc0, 23'h07ac96, 22'h01c3a1, 22'h00da07, 11'h00e};
                default: begin
                    o_coef = {26'h2083149, 23'h10c7c9, 23'h067ee2, 22'h01659c, 22'h00a180, 11'h009};
                end
            endcase
        end
    end

endmodule

/* rtl/invsqrt_unpack.sv */
`timescale 1ns/1ps
`include "invsqrt_params.svh"

module invsqrt_unpack import invsqrt_pkg::*; (
    input  fp32_t   i_x,
    output unpack_t o_stage
);

    localparam int BIAS    = (1 << (`FP_EXP_W - 1)) - 1;
    // (3*bias - 1 - e) / 2 is the exponent of a result in [0.5, 1)
    localparam int EXP_SUM = 3 * BIAS - 1;

    fp32_t                x;
    logic                 exp_ones;
    logic                 man_zero;
    case_flags_t          flags;
    logic [`FP_EXP_W+1:0] exp_diff;
    logic                 above;
    logic [Y_W-2:0]       man_low;
    logic [Y_W-1:0]       y;
    coef_t                coef;

    // denormals become zero, sign included
    assign x = (i_x.exp == '0 && i_x.man != '0) ? '0 : i_x;

    assign exp_ones = (x.exp == '1);
    assign man_zero = (x.man == '0);

    // negative normals and -inf
    assign flags.neg          = x.sign && ((exp_ones && man_zero) || (x.exp != '0 && !exp_ones));
    assign flags.zero         = (x.exp == '0) && man_zero;
    assign flags.nan_zero_neg = (exp_ones && !man_zero) || flags.zero || flags.neg;
    assign flags.pos_inf      = !x.sign && exp_ones && man_zero;

    assign exp_diff = (`FP_EXP_W+2)'(EXP_SUM) - {2'b00, x.exp};

    // centre of the segment is the three top bits followed by a one
    assign above   = x.man[`FP_MAN_W-4];
    assign man_low = x.man[`FP_MAN_W-5:0];
    // magnitude of the offset, the sign travels in above
    assign y = above ? {1'b0, man_low} : ({1'b1, {(Y_W-1){1'b0}}} - {1'b0, man_low});

    // biased exponent lsb low means an odd unbiased exponent
    invsqrt_coef_rom u_coef_rom (
        .i_odd_exp (!x.exp[0]),
        .i_seg     (x.man[`FP_MAN_W-1 -: 3]),
        .o_coef    (coef)
    );

    assign o_stage = '{
        flags: flags,
        above: above,
        exp:   exp_diff[`FP_EXP_W:1],
        coef:  coef,
        y:     y
    };

endmodule

/* rtl/pipe_stage.sv */
`timescale 1ns/1ps

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     i_clk,
    input  logic     i_arst_n,
    input  logic     i_valid,
    output logic     o_ready,
    input  payload_t i_data,
    output logic     o_valid,
    input  logic     i_ready,
    output payload_t o_data
);

    logic     full_q;
    payload_t data_q;

    // room when empty or when the held beat leaves this cycle
    assign o_ready = !full_q || i_ready;
    assign o_valid = full_q;
    assign o_data  = data_q;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            full_q <= 1'b0;
        end else if (o_ready) begin
            full_q <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_ready && i_valid) begin
            data_q <= i_data;
        end
    end

endmodule

/* rtl/invsqrt_taylor.sv */
`timescale 1ns/1ps
`include "invsqrt_params.svh"

// r = a0 -+ a1*y + z*(a2 -+ a3*y + z*(a4 -+ a5*y)) with z = y*y
module invsqrt_taylor import invsqrt_pkg::*; (
    input  logic    i_clk,
    input  logic    i_arst_n,
    input  logic    i_valid,
    output logic    o_ready,
    input  unpack_t i_stage,
    output logic    o_valid,
    input  logic    i_ready,
    output sum_in_t o_stage
);

    prod_t              prod_d;
    prod_t              prod_q;
    inner_t             inner_d;
    inner_t             inner_q;
    group_t             group_d;
    group_t             group_q;
    sum_in_t            sum_d;
    logic               s2_valid;
    logic               s3_valid;
    logic               s4_valid;
    logic               s3_ready;
    logic               s4_ready;
    logic               s5_ready;
    logic [A3_W-4:0]    y_hi;
    logic [A5_W-4:0]    y_a5;
    logic [A45_W-1:0]   a4_lo;
    logic [A4Z2_W-1:0]  a4z_w;
    logic [A4Z_W-1:0]   a4z;
    logic [GRP_W-1:0]   a2_a4z;
    logic [ZG1_W-1:0]   zg_w;

    //////////////////////////////////////////////////
    // stage 2 products of the offset
    // each factor keeps only the top bits of y it needs
    assign y_hi = i_stage.y[Y_W-1 -: A3_W-3];
    assign y_a5 = i_stage.y[Y_W-1 -: A5_W-3];

    assign prod_d = '{
        flags: i_stage.flags,
        above: i_stage.above,
        exp:   i_stage.exp,
        a0:    i_stage.coef.a0,
        a2:    i_stage.coef.a2,
        a4:    i_stage.coef.a4,
        a5y:   A5Y_W'(i_stage.coef.a5) * A5Y_W'(y_a5),
        a1y_w: A1Y1_W'(i_stage.coef.a1) * A1Y1_W'(i_stage.y),
        z_w:   Z2_W'(y_hi) * Z2_W'(y_hi),
        a3y_w: A3Y2_W'(i_stage.coef.a3) * A3Y2_W'(y_hi)
    };

    pipe_stage #(.payload_t(prod_t)) u_stage2 (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_valid  (i_valid),
        .o_ready  (o_ready),
        .i_data   (prod_d),
        .o_valid  (s2_valid),
        .i_ready  (s3_ready),
        .o_data   (prod_q)
    );

    //////////////////////////////////////////////////
    // stage 3 innermost term and first rounding
    assign a4_lo = prod_q.a4[A45_W-1:0];

    // z_top is the unrounded square, the a4 product uses it
    assign inner_d = '{
        flags: prod_q.flags,
        above: prod_q.above,
        exp:   prod_q.exp,
        a0:    prod_q.a0,
        a2:    prod_q.a2,
        a45:   prod_q.above ? a4_lo - A45_W'(prod_q.a5y) : a4_lo + A45_W'(prod_q.a5y),
        a1y:   A1Y_W'(rne_round(64'(prod_q.a1y_w), `FP_RNE1_W)),
        z:     Z_W'(rne_round(64'(prod_q.z_w), `FP_RNE2_W)),
        z_top: prod_q.z_w[Z2_W-1 -: ZT_W],
        a3y:   A3Y_W'(rne_round(64'(prod_q.a3y_w), `FP_RNE2_W))
    };

    pipe_stage #(.payload_t(inner_t)) u_stage3 (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_valid  (s2_valid),
        .o_ready  (s3_ready),
        .i_data   (inner_d),
        .o_valid  (s3_valid),
        .i_ready  (s4_ready),
        .o_data   (inner_q)
    );

    //////////////////////////////////////////////////
    // stage 4 middle group
    assign a4z_w  = A4Z2_W'(inner_q.a45) * A4Z2_W'(inner_q.z_top);
    assign a4z    = A4Z_W'(rne_round(64'(a4z_w), `FP_RNE2_W));
    assign a2_a4z = inner_q.a2[GRP_W-1:0] + GRP_W'(a4z);

    assign group_d = '{
        flags: inner_q.flags,
        above: inner_q.above,
        exp:   inner_q.exp,
        a0:    inner_q.a0,
        a1y:   inner_q.a1y,
        z:     inner_q.z,
        grp:   inner_q.above ? a2_a4z - GRP_W'(inner_q.a3y) : a2_a4z + GRP_W'(inner_q.a3y)
    };

    pipe_stage #(.payload_t(group_t)) u_stage4 (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_valid  (s3_valid),
        .o_ready  (s4_ready),
        .i_data   (group_d),
        .o_valid  (s4_valid),
        .i_ready  (s5_ready),
        .o_data   (group_q)
    );

    //////////////////////////////////////////////////
    // stage 5 outer product with z
    assign zg_w = ZG1_W'(group_q.z) * ZG1_W'(group_q.grp);

    assign sum_d = '{
        flags: group_q.flags,
        above: group_q.above,
        exp:   group_q.exp,
        a0:    group_q.a0,
        a1y:   group_q.a1y,
        zg:    ZG_W'(rne_round(64'(zg_w), `FP_RNE1_W))
    };

    pipe_stage #(.payload_t(sum_in_t)) u_stage5 (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_valid  (s4_valid),
        .o_ready  (s5_ready),
        .i_data   (sum_d),
        .o_valid  (o_valid),
        .i_ready  (i_ready),
        .o_data   (o_stage)
    );

endmodule

/* rtl/invsqrt_pack.sv */
`timescale 1ns/1ps
`include "invsqrt_params.svh"

module invsqrt_pack import invsqrt_pkg::*; (
    input  sum_in_t i_stage,
    output fp32_t   o_result,
    output logic    o_invalid_op,
    output logic    o_divide_by_zero
);

    logic [SUM_W-1:0]     sum_w;
    logic [RES_W-1:0]     sum;
    logic [`FP_EXP_W-1:0] exp_up;
    logic [`FP_EXP_W-1:0] exp_dn;
    fp32_t                norm;

    assign sum_w = i_stage.above
        ? SUM_W'(i_stage.a0) - SUM_W'(i_stage.a1y) + SUM_W'(i_stage.zg)
        : SUM_W'(i_stage.a0) + SUM_W'(i_stage.a1y) + SUM_W'(i_stage.zg);

    // msb of sum weighs 1.0, next bit 0.5
    assign sum = RES_W'(rne_round(64'(sum_w), `FP_RNE0_W));

    assign exp_up = i_stage.exp + `FP_EXP_W'(1);
    assign exp_dn = i_stage.exp - `FP_EXP_W'(1);

    always_comb begin
        norm.sign = 1'b0;
        if (sum[RES_W-1]) begin
            norm.exp = exp_up;
            norm.man = sum[RES_W-2:1];
        end else if (sum[RES_W-2]) begin
            norm.exp = i_stage.exp;
            norm.man = sum[RES_W-3:0];
        end else begin
            norm.exp = exp_dn;
            norm.man = {sum[RES_W-4:0], 1'b0};
        end
    end

    // special operands override the series result
    always_comb begin
        if (i_stage.flags.nan_zero_neg) begin
            o_result = `INVSQRT_QNAN;
        end else if (i_stage.flags.pos_inf) begin
            o_result = '0;
        end else begin
            o_result = norm;
        end
    end

    assign o_invalid_op     = i_stage.flags.neg;
    assign o_divide_by_zero = i_stage.flags.zero;

endmodule

/* rtl/invsqrt_top.sv */
`timescale 1ns/1ps

module invsqrt_top import invsqrt_pkg::*; (
    input  logic  i_clk,
    input  logic  i_arst_n,
    input  logic  i_valid,
    output logic  o_ready,
    input  fp32_t i_x,
    output logic  o_valid,
    input  logic  i_ready,
    output fp32_t o_result,
    output logic  o_invalid_op,
    output logic  o_divide_by_zero
);

    unpack_t unpack_d;
    unpack_t unpack_q;
    logic    s1_valid;
    logic    taylor_ready;
    sum_in_t sum_q;
    logic    sum_valid;
    logic    out_ready;
    fp32_t   pack_result;
    logic    pack_invalid;
    logic    pack_div0;

    invsqrt_unpack u_unpack (
        .i_x     (i_x),
        .o_stage (unpack_d)
    );

    // stage 1
    pipe_stage #(.payload_t(unpack_t)) u_stage1 (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_valid  (i_valid),
        .o_ready  (o_ready),
        .i_data   (unpack_d),
        .o_valid  (s1_valid),
        .i_ready  (taylor_ready),
        .o_data   (unpack_q)
    );

    // stages 2 to 5
    invsqrt_taylor u_taylor (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_valid  (s1_valid),
        .o_ready  (taylor_ready),
        .i_stage  (unpack_q),
        .o_valid  (sum_valid),
        .i_ready  (out_ready),
        .o_stage  (sum_q)
    );

    invsqrt_pack u_pack (
        .i_stage          (sum_q),
        .o_result         (pack_result),
        .o_invalid_op     (pack_invalid),
        .o_divide_by_zero (pack_div0)
    );

    // stage 6 holds the packed word and flags
    pipe_stage #(.payload_t(result_t)) u_stage6 (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_valid  (sum_valid),
        .o_ready  (out_ready),
        .i_data   ({pack_result, pack_invalid, pack_div0}),
        .o_valid  (o_valid),
        .i_ready  (i_ready),
        .o_data   ({o_result, o_invalid_op, o_divide_by_zero})
    );

endmodule

/* tests/invsqrt_tb.sv */
`timescale 1ns/1ps
`include "invsqrt_params.svh"

module invsqrt_tb import invsqrt_pkg::*; ();

    localparam int N_VEC      = 24;
    localparam int MAX_CYCLES = 4 * N_VEC + `INVSQRT_LATENCY + 100;

    logic  i_clk;
    logic  i_arst_n;
    logic  i_valid;
    logic  o_ready;
    fp32_t i_x;
    logic  o_valid;
    logic  i_ready;
    fp32_t o_result;
    logic  o_invalid_op;
    logic  o_divide_by_zero;

    // three words per vector for operand, result and flags
    logic [31:0] vec_mem [0:3*N_VEC-1];
    // results of the unstalled pass with the flags on top
    logic [33:0] stream_out [0:N_VEC-1];

    int          idx_q[$];
    int          acc_q[$];
    int          cur_idx;
    int          cycle = 0;
    int          errors = 0;
    int          checks = 0;
    int          outputs_seen = 0;
    integer      seed = 79348;
    logic        stall_mode;
    logic        sink_off;
    logic        load_ok;
    logic        hold_pending;
    logic [31:0] held_result;
    logic [1:0]  held_flags;

    invsqrt_top DUT (
        .i_clk            (i_clk),
        .i_arst_n         (i_arst_n),
        .i_valid          (i_valid),
        .o_ready          (o_ready),
        .i_x              (i_x),
        .o_valid          (o_valid),
        .i_ready          (i_ready),
        .o_result         (o_result),
        .o_invalid_op     (o_invalid_op),
        .o_divide_by_zero (o_divide_by_zero)
    );

    always #20 i_clk = ~i_clk;

    // sink held off through the reset check
    // in stall mode it stalls about one cycle in four
    always @(posedge i_clk) begin
        if (sink_off) begin
            i_ready <= 1'b0;
        end else if (stall_mode) begin
            i_ready <= (($random(seed) & 3) != 0);
        end else begin
            i_ready <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // expected values

    // even powers of two and special results must match bit for bit
    function automatic bit exact_expected(input logic [31:0] x, input logic [31:0] want);
        bit even_pow2;
        even_pow2 = !x[31] && x[22:0] == '0 && x[30:23] != 8'h00
            && x[30:23] != 8'hFF && x[23];
        return even_pow2 || want == `INVSQRT_QNAN || want == 32'h0;
    endfunction

    // positive floats order like their bit patterns, so one ulp is one step
    function automatic bit result_matches(input logic [31:0] x, input logic [31:0] want,
                                          input logic [31:0] got);
        logic [31:0] diff;
        if ($isunknown(got)) begin
            return 1'b0;
        end
        if (exact_expected(x, want)) begin
            return got == want;
        end
        diff = (got > want) ? got - want : want - got;
        return diff <= 32'd1;
    endfunction

    task automatic check_output(input int idx, input int acc);
        logic [31:0] x;
        logic [31:0] want;
        logic [31:0] got;
        logic [1:0]  want_flags;
        logic [1:0]  got_flags;
        x          = vec_mem[3*idx];
        want       = vec_mem[3*idx+1];
        want_flags = vec_mem[3*idx+2][1:0];
        got        = o_result;
        got_flags  = {o_invalid_op, o_divide_by_zero};
        checks     = checks + 1;
        if (!result_matches(x, want, got)) begin
            $display("FAILED at %0t: input %h gave %h, expected %h", $time, x, got, want);
            errors = errors + 1;
        end
        if (got_flags !== want_flags) begin
            $display("FAILED at %0t: input %h gave flags %b, expected %b",
                     $time, x, got_flags, want_flags);
            errors = errors + 1;
        end
        if (!stall_mode) begin
            if (cycle - acc != `INVSQRT_LATENCY) begin
                $display("FAILED at %0t: input %h took %0d cycles, expected %0d",
                         $time, x, cycle - acc, `INVSQRT_LATENCY);
                errors = errors + 1;
            end
            stream_out[idx] = {got_flags, got};
        end else if ({got_flags, got} !== stream_out[idx]) begin
            $display("FAILED at %0t: input %h gave %h under stalls, %h without",
                     $time, x, got, stream_out[idx][31:0]);
            errors = errors + 1;
        end
    endtask

    //////////////////////////////////////////////////
    // the monitor samples the values settled before each edge
    always @(posedge i_clk) begin
        cycle = cycle + 1;
        if (cycle > MAX_CYCLES) begin
            $display("timeout: no finish after %0d cycles, %0d results still pending",
                     cycle, idx_q.size());
            $display("Testbench failed");
            $finish;
        end else begin
            if (hold_pending) begin
                if (!o_valid || o_result !== held_result
                    || {o_invalid_op, o_divide_by_zero} !== held_flags) begin
                    $display("FAILED at %0t: output changed while the sink stalled", $time);
                    errors = errors + 1;
                end
            end
            hold_pending = o_valid && !i_ready;
            held_result  = o_result;
            held_flags   = {o_invalid_op, o_divide_by_zero};
            if (i_valid && o_ready) begin
                idx_q.push_back(cur_idx);
                acc_q.push_back(cycle);
            end
            if (o_valid && i_ready) begin
                if (idx_q.size() == 0) begin
                    $display("the DUT delivered a result with no input pending at %0t", $time);
                    errors = errors + 1;
                end else begin
                    check_output(idx_q.pop_front(), acc_q.pop_front());
                end
                outputs_seen = outputs_seen + 1;
            end
        end
    end

    //////////////////////////////////////////////////
    // stimulus
    task automatic drive_beat(input int idx);
        i_valid <= 1'b1;
        i_x     <= vec_mem[3*idx];
        cur_idx <= idx;
        @(posedge i_clk);
        while (!o_ready) begin
            @(posedge i_clk);
        end
    endtask

    task automatic run_pass(input bit stalled, input string name);
        int base_err;
        int base_out;
        base_err = errors;
        base_out = outputs_seen;
        stall_mode <= stalled;
        @(posedge i_clk);
        for (int i = 0; i < N_VEC; i++) begin
            drive_beat(i);
        end
        i_valid <= 1'b0;
        @(posedge i_clk);
        while (outputs_seen - base_out < N_VEC) begin
            @(posedge i_clk);
        end
        $display("test %s: %0d results, %0d errors", name, outputs_seen - base_out,
                 errors - base_err);
    endtask

    initial begin
        int base_err;
        i_clk        = 1'b0;
        i_arst_n     = 1'b0;
        i_valid      = 1'b0;
        i_ready      = 1'b0;
        i_x          = '0;
        cur_idx      = 0;
        stall_mode   = 1'b0;
        sink_off     = 1'b1;
        hold_pending = 1'b0;
        for (int i = 0; i < 3 * N_VEC; i++) begin
            vec_mem[i] = 'x;
        end
        $readmemh("tests/invsqrt_tests.hex", vec_mem);
        load_ok = !$isunknown(vec_mem[3*N_VEC-1]);

        repeat (10) @(posedge i_clk);
        i_arst_n <= 1'b1;
        repeat (2) @(posedge i_clk);

        // o_ready now depends on the stage valid bits alone
        base_err = errors;
        checks   = checks + 1;
        if (o_valid !== 1'b0 || o_ready !== 1'b1) begin
            $display("FAILED at %0t: after reset o_valid is %b and o_ready is %b",
                     $time, o_valid, o_ready);
            errors = errors + 1;
        end
        $display("test reset state: %0d errors", errors - base_err);
        sink_off <= 1'b0;

        if (!load_ok) begin
            $display("vector file tests/invsqrt_tests.hex is missing or too short");
            errors = errors + 1;
        end else begin
            run_pass(1'b0, "streaming with the sink always ready");
            run_pass(1'b1, "random back-pressure");
        end

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* tests/invsqrt_tests.hex */
// columns: input word, expected result, expected flags
// flags: bit 1 invalid operation, bit 0 divide by zero
3F800000 3F800000 0
40800000 3F000000 0
3E800000 40000000 0
42800000 3E000000 0
44800000 3D000000 0
35800000 44800000 0
7E800000 20000000 0
00800000 5F000000 0
40000000 3F3504F3 0
3F000000 3FB504F3 0
41100000 3EAAAAAB 0
40100000 3F2AAAAB 0
40C80000 3ECCCCCD 0
40400000 3F13CD3A 0
41440000 3E924925 0
BF800000 7FC00000 2
FF800000 7FC00000 2
7FC00000 7FC00000 0
7F800001 7FC00000 0
00000000 7FC00000 1
80000000 7FC00000 1
00000001 7FC00000 1
7F800000 00000000 0
C0200000 7FC00000 2

/* vlog.f */
+incdir+rtl
rtl/invsqrt_pkg.sv
rtl/invsqrt_coef_rom.sv
rtl/invsqrt_unpack.sv
rtl/pipe_stage.sv
rtl/invsqrt_taylor.sv
rtl/invsqrt_pack.sv
rtl/invsqrt_top.sv
tests/invsqrt_tb.sv

/* Bender.yml */
package:
  name: invsqrt

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/invsqrt_pkg.sv
      - rtl/invsqrt_coef_rom.sv
      - rtl/invsqrt_unpack.sv
      - rtl/pipe_stage.sv
      - rtl/invsqrt_taylor.sv
      - rtl/invsqrt_pack.sv
      - rtl/invsqrt_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/invsqrt_tb.sv
